// ==== rtl/trace_pkg.sv ====
// Trace pipeline package
// Shared widths, decode classes, exception and debug cause codes for the
// instruction-retirement trace pipeline
`default_nettype none

package trace_pkg;

  // Width of data, addresses and the shadow mcause
  localparam int unsigned XLEN = 32;

  // Width of the debug cause field on every stage link and on rvfi_dbg_o
  localparam int unsigned DBG_W = 3;

  ////////////////////
  // Instruction words
  ////////////////////

  // The only two SYSTEM encodings that get a class of their own
  localparam logic [XLEN-1:0] INSN_ECALL  = 32'h0000_0073;
  localparam logic [XLEN-1:0] INSN_EBREAK = 32'h0010_0073;

  ////////////////////
  // Decode classes
  ////////////////////

  // One class per word, picked by decode in a fixed priority
  typedef enum logic [2:0] {
    OP_NORMAL    = 3'd0,
    OP_ECALL     = 3'd1,
    OP_EBREAK    = 3'd2,
    OP_ILLEGAL   = 3'd3,   // low two bits are not 2'b11
    OP_FETCH_ERR = 3'd4    // Wishbone err ended the fetch
  } opcode_e;

  ////////////////////
  // Cause codes
  ////////////////////

  // Exception causes as they appear in mcause[5:0]
  // EXC_NONE rides along with OP_NORMAL and never reaches mcause
  typedef enum logic [5:0] {
    EXC_NONE        = 6'd0,
    EXC_FETCH_FAULT = 6'd1,
    EXC_ILLEGAL     = 6'd2,
    EXC_BREAKPOINT  = 6'd3,
    EXC_ECALL_M     = 6'd11
  } exc_cause_e;

  // Machine external interrupt code, written to mcause with bit 31 set
  localparam logic [5:0] INT_CAUSE_EXT = 6'd11;

  // Debug entry causes, in the dcsr.cause encoding
  typedef enum logic [DBG_W-1:0] {
    DBG_NONE    = 3'd0,
    DBG_EBREAK  = 3'd1,
    DBG_TRIGGER = 3'd2,
    DBG_HALTREQ = 3'd3
  } dbg_cause_e;

endpackage

`default_nettype wire

// ==== rtl/trace_fetch.sv ====
// Trace pipeline fetch stage
// Wishbone classic master that reads words at sequential addresses from the
// boot address and tags each word with pending interrupt and debug acks
`timescale 1ns/1ps
`default_nettype none

module trace_fetch #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0080
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Wishbone classic master
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [trace_pkg::XLEN-1:0]  wb_adr_o,
  output logic [3:0]                  wb_sel_o,
  input  logic [trace_pkg::XLEN-1:0]  wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,
  // Event acknowledges
  input  logic                        irq_ack_i,
  input  logic                        dbg_ack_i,
  input  logic [trace_pkg::DBG_W-1:0] dbg_cause_i,
  // Link to decode
  output logic                        f_valid_o,
  input  logic                        f_ready_i,
  output logic [trace_pkg::XLEN-1:0]  f_pc_o,
  output logic [trace_pkg::XLEN-1:0]  f_insn_o,
  output logic                        f_err_o,
  output logic                        f_irq_o,
  output logic [trace_pkg::DBG_W-1:0] f_dbg_o
);
  import trace_pkg::*;

  typedef enum logic {
    IDLE,
    WAIT
  } state_e;

  state_e           state_q;
  logic [XLEN-1:0]  pc_q;
  logic             irq_pend_q;
  logic [DBG_W-1:0] dbg_pend_q;
  logic             done;
  logic             can_issue;
  logic             irq_attach;
  logic [DBG_W-1:0] dbg_attach;

  ////////////////////
  // Bus request
  ////////////////////

  // The transfer ends on ack or on err, whichever the slave returns
  assign done = (state_q == WAIT) && (wb_ack_i || wb_err_i);

  // A request only goes out when its word is sure to find room
  // in the output register, so an ack is never dropped
  assign can_issue = !f_valid_o || f_ready_i;

  // Cyc and stb rise and fall together and the address comes straight from pc
  assign wb_cyc_o = (state_q == WAIT);
  assign wb_stb_o = (state_q == WAIT);
  assign wb_we_o  = 1'b0;
  assign wb_sel_o = 4'hF;
  assign wb_adr_o = pc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      pc_q    <= BOOT_ADDR;
    end else begin
      case (state_q)
        IDLE: begin
          if (can_issue) begin
            state_q <= WAIT;
          end
        end
        WAIT: begin
          // Address is held until the slave ends the cycle
          if (done) begin
            state_q <= IDLE;
            pc_q    <= pc_q + XLEN'(4);
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  ////////////////////
  // Event latches
  ////////////////////

  // An ack that lands in the same cycle as the bus ack goes onto this word
  assign irq_attach = irq_pend_q || irq_ack_i;
  assign dbg_attach = dbg_ack_i ? dbg_cause_i : dbg_pend_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      dbg_pend_q <= DBG_NONE;
    end else begin
      // Cleared once the content has been handed to a completed word
      if (done) begin
        irq_pend_q <= 1'b0;
      end else if (irq_ack_i) begin
        irq_pend_q <= 1'b1;
      end
      if (done) begin
        dbg_pend_q <= DBG_NONE;
      end else if (dbg_ack_i) begin
        dbg_pend_q <= dbg_cause_i;
      end
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      f_valid_o <= 1'b0;
    end else if (done) begin
      f_valid_o <= 1'b1;
    end else if (f_ready_i) begin
      f_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done) begin
      f_pc_o   <= pc_q;
      f_insn_o <= wb_dat_i;
      f_err_o  <= wb_err_i;
      f_irq_o  <= irq_attach;
      f_dbg_o  <= dbg_attach;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/trace_decode.sv ====
// Trace pipeline decode stage
// Sorts each fetched word into a decode class and registers it together
// with its exception cause
`timescale 1ns/1ps
`default_nettype none

module trace_decode (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Link from fetch
  input  logic                        f_valid_i,
  output logic                        f_ready_o,
  input  logic [trace_pkg::XLEN-1:0]  f_pc_i,
  input  logic [trace_pkg::XLEN-1:0]  f_insn_i,
  input  logic                        f_err_i,
  input  logic                        f_irq_i,
  input  logic [trace_pkg::DBG_W-1:0] f_dbg_i,
  // Link to retire
  output logic                        d_valid_o,
  input  logic                        d_ready_i,
  output logic [trace_pkg::XLEN-1:0]  d_pc_o,
  output logic [trace_pkg::XLEN-1:0]  d_insn_o,
  output logic                        d_irq_o,
  output logic [trace_pkg::DBG_W-1:0] d_dbg_o,
  output trace_pkg::opcode_e          d_op_o,
  output trace_pkg::exc_cause_e       d_cause_o
);
  import trace_pkg::*;

  opcode_e    op;
  exc_cause_e cause;
  logic       load;

  // Room when empty or when the held word leaves on this edge
  assign f_ready_o = !d_valid_o || d_ready_i;
  assign load      = f_valid_i && f_ready_o;

  // Priority is fetch error, illegal, ecall, ebreak, then normal
  always_comb begin
    if (f_err_i) begin
      op    = OP_FETCH_ERR;
      cause = EXC_FETCH_FAULT;
    end else if (f_insn_i[1:0] != 2'b11) begin
      op    = OP_ILLEGAL;
      cause = EXC_ILLEGAL;
    end else if (f_insn_i == INSN_ECALL) begin
      op    = OP_ECALL;
      cause = EXC_ECALL_M;
    end else if (f_insn_i == INSN_EBREAK) begin
      op    = OP_EBREAK;
      cause = EXC_BREAKPOINT;
    end else begin
      op    = OP_NORMAL;
      cause = EXC_NONE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d_valid_o <= 1'b0;
    end else if (f_ready_o) begin
      d_valid_o <= f_valid_i;
    end
  end

  // Payload moves along with the word it belongs to
  always_ff @(posedge clk_i) begin
    if (load) begin
      d_pc_o    <= f_pc_i;
      d_insn_o  <= f_insn_i;
      d_irq_o   <= f_irq_i;
      d_dbg_o   <= f_dbg_i;
      d_op_o    <= op;
      d_cause_o <= cause;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/trace_retire.sv ====
// Trace pipeline retire stage
// Emits one RVFI-style record per word, flags the record that follows a trap
// as an interrupt entry and keeps a shadow copy of mcause
`timescale 1ns/1ps
`default_nettype none

module trace_retire (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Link from decode
  input  logic                        d_valid_i,
  output logic                        d_ready_o,
  input  logic [trace_pkg::XLEN-1:0]  d_pc_i,
  input  logic [trace_pkg::XLEN-1:0]  d_insn_i,
  input  logic                        d_irq_i,
  input  logic [trace_pkg::DBG_W-1:0] d_dbg_i,
  input  trace_pkg::opcode_e          d_op_i,
  input  trace_pkg::exc_cause_e       d_cause_i,
  // Trace sink
  input  logic                        trace_ready_i,
  output logic                        rvfi_valid_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_pc_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_insn_o,
  output logic                        rvfi_intr_o,
  output logic [1:0]                  rvfi_trap_o,   // [0] exception, [1] debug
  output logic [5:0]                  rvfi_cause_o,
  output logic [trace_pkg::DBG_W-1:0] rvfi_dbg_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_mcause_o
);
  import trace_pkg::*;

  logic            load;
  logic            retire;
  logic            exc;
  logic            prev_trap;
  logic            trap_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mcause_base;
  logic [XLEN-1:0] mcause_next;

  assign retire    = rvfi_valid_o && trace_ready_i;
  assign d_ready_o = !rvfi_valid_o || trace_ready_i;
  assign load      = d_valid_i && d_ready_o;

  ////////////////////
  // Record fields
  ////////////////////

  assign exc = (d_op_i != OP_NORMAL);

  // A held record is always the one retiring when a new one loads,
  // otherwise the last retired state sits in the carried registers
  assign prev_trap   = rvfi_valid_o ? rvfi_trap_o[0] : trap_q;
  assign mcause_base = rvfi_valid_o ? rvfi_mcause_o : mcause_q;

  // Exceptions win over an interrupt attached to the same word
  always_comb begin
    if (exc) begin
      mcause_next = {{(XLEN-6){1'b0}}, d_cause_i};
    end else if (d_irq_i) begin
      mcause_next = {1'b1, {(XLEN-7){1'b0}}, INT_CAUSE_EXT};
    end else begin
      mcause_next = mcause_base;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o <= 1'b0;
    end else if (d_ready_o) begin
      rvfi_valid_o <= d_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      rvfi_pc_o      <= d_pc_i;
      rvfi_insn_o    <= d_insn_i;
      rvfi_intr_o    <= d_irq_i || prev_trap;
      rvfi_trap_o[0] <= exc;
      // Only ebreak enters debug here, and always along with an exception
      rvfi_trap_o[1] <= (d_op_i == OP_EBREAK);
      rvfi_cause_o   <= d_cause_i;
      rvfi_dbg_o     <= d_dbg_i;
      rvfi_mcause_o  <= mcause_next;
    end
  end

  ////////////////////
  // Retired state
  ////////////////////

  // Trap flag and shadow mcause of the most recently retired record
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_q   <= 1'b0;
      mcause_q <= '0;
    end else if (retire) begin
      trap_q   <= rvfi_trap_o[0];
      mcause_q <= rvfi_mcause_o;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/trace_top.sv ====
// Trace pipeline top level
// Fetch, decode and retire chained by valid/ready, back-pressure from the sink
`timescale 1ns/1ps
`default_nettype none

module trace_top #(
  parameter logic [31:0] BOOT_ADDR = 32'h0000_0080
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Wishbone classic master
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [trace_pkg::XLEN-1:0]  wb_adr_o,
  output logic [3:0]                  wb_sel_o,
  input  logic [trace_pkg::XLEN-1:0]  wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,
  // Event acknowledges
  input  logic                        irq_ack_i,
  input  logic                        dbg_ack_i,
  input  logic [trace_pkg::DBG_W-1:0] dbg_cause_i,
  // Trace output
  input  logic                        trace_ready_i,
  output logic                        rvfi_valid_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_pc_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_insn_o,
  output logic                        rvfi_intr_o,
  output logic [1:0]                  rvfi_trap_o,
  output logic [5:0]                  rvfi_cause_o,
  output logic [trace_pkg::DBG_W-1:0] rvfi_dbg_o,
  output logic [trace_pkg::XLEN-1:0]  rvfi_mcause_o
);
  import trace_pkg::*;

  // Fetch to decode
  logic             f_valid;
  logic             f_ready;
  logic [XLEN-1:0]  f_pc;
  logic [XLEN-1:0]  f_insn;
  logic             f_err;
  logic             f_irq;
  logic [DBG_W-1:0] f_dbg;

  // Decode to retire
  logic             d_valid;
  logic             d_ready;
  logic [XLEN-1:0]  d_pc;
  logic [XLEN-1:0]  d_insn;
  logic             d_irq;
  logic [DBG_W-1:0] d_dbg;
  opcode_e          d_op;
  exc_cause_e       d_cause;

  trace_fetch #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_fetch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_sel_o    (wb_sel_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .wb_err_i    (wb_err_i),
    .irq_ack_i   (irq_ack_i),
    .dbg_ack_i   (dbg_ack_i),
    .dbg_cause_i (dbg_cause_i),
    .f_valid_o   (f_valid),
    .f_ready_i   (f_ready),
    .f_pc_o      (f_pc),
    .f_insn_o    (f_insn),
    .f_err_o     (f_err),
    .f_irq_o     (f_irq),
    .f_dbg_o     (f_dbg)
  );

  trace_decode u_decode (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .f_valid_i (f_valid),
    .f_ready_o (f_ready),
    .f_pc_i    (f_pc),
    .f_insn_i  (f_insn),
    .f_err_i   (f_err),
    .f_irq_i   (f_irq),
    .f_dbg_i   (f_dbg),
    .d_valid_o (d_valid),
    .d_ready_i (d_ready),
    .d_pc_o    (d_pc),
    .d_insn_o  (d_insn),
    .d_irq_o   (d_irq),
    .d_dbg_o   (d_dbg),
    .d_op_o    (d_op),
    .d_cause_o (d_cause)
  );

  trace_retire u_retire (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .d_valid_i     (d_valid),
    .d_ready_o     (d_ready),
    .d_pc_i        (d_pc),
    .d_insn_i      (d_insn),
    .d_irq_i       (d_irq),
    .d_dbg_i       (d_dbg),
    .d_op_i        (d_op),
    .d_cause_i     (d_cause),
    .trace_ready_i (trace_ready_i),
    .rvfi_valid_o  (rvfi_valid_o),
    .rvfi_pc_o     (rvfi_pc_o),
    .rvfi_insn_o   (rvfi_insn_o),
    .rvfi_intr_o   (rvfi_intr_o),
    .rvfi_trap_o   (rvfi_trap_o),
    .rvfi_cause_o  (rvfi_cause_o),
    .rvfi_dbg_o    (rvfi_dbg_o),
    .rvfi_mcause_o (rvfi_mcause_o)
  );

endmodule

`default_nettype wire

// ==== bench/trace_retire_asserts.sv ====
// Retire stage assertions
// Trap-to-interrupt, debug capture, valid hold and reset rules on the trace port
`timescale 1ns/1ps
`default_nettype none

module trace_retire_asserts (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        d_valid_i,
  input logic                        d_ready_i,
  input logic [trace_pkg::DBG_W-1:0] d_dbg_i,
  input logic                        trace_ready_i,
  input logic                        rvfi_valid_i,
  input logic [trace_pkg::XLEN-1:0]  rvfi_pc_i,
  input logic [trace_pkg::XLEN-1:0]  rvfi_insn_i,
  input logic                        rvfi_intr_i,
  input logic [1:0]                  rvfi_trap_i,
  input logic [trace_pkg::DBG_W-1:0] rvfi_dbg_i
);
  import trace_pkg::*;

  logic       retire;
  logic       trap_seen_q;
  logic [7:0] dbg_in_q;
  logic [7:0] dbg_out_q;

  assign retire = rvfi_valid_i && trace_ready_i;

  // Debug acks captured into retire versus debug records that have left
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trap_seen_q <= 1'b0;
      dbg_in_q    <= '0;
      dbg_out_q   <= '0;
    end else begin
      if (d_valid_i && d_ready_i && (d_dbg_i != DBG_NONE)) begin
        dbg_in_q <= dbg_in_q + 8'd1;
      end
      if (retire) begin
        trap_seen_q <= rvfi_trap_i[0];
        if (rvfi_dbg_i != DBG_NONE) begin
          dbg_out_q <= dbg_out_q + 8'd1;
        end
      end
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // The record shown after a trapped one enters the handler
  a_trap_intr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i && trap_seen_q |-> rvfi_intr_i)
    else $error("record after a trapped record has rvfi_intr_o low");

  // A debug record needs an acknowledge that has not yet been used up
  a_dbg_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i && (rvfi_dbg_i != DBG_NONE) |-> (dbg_in_q != dbg_out_q))
    else $error("debug record without a captured debug acknowledge");

  // A stalled record stays put
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvfi_valid_i && !trace_ready_i |=>
      rvfi_valid_i && $stable(rvfi_pc_i) && $stable(rvfi_insn_i))
    else $error("record changed or vanished while the sink stalled");

  a_reset: assert property (@(posedge clk_i) !rst_ni |-> !rvfi_valid_i)
    else $error("rvfi_valid_o high during reset");

endmodule

bind trace_retire trace_retire_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .d_valid_i     (d_valid_i),
  .d_ready_i     (d_ready_o),
  .d_dbg_i       (d_dbg_i),
  .trace_ready_i (trace_ready_i),
  .rvfi_valid_i  (rvfi_valid_o),
  .rvfi_pc_i     (rvfi_pc_o),
  .rvfi_insn_i   (rvfi_insn_o),
  .rvfi_intr_i   (rvfi_intr_o),
  .rvfi_trap_i   (rvfi_trap_o),
  .rvfi_dbg_i    (rvfi_dbg_o)
);

`default_nettype wire

// ==== bench/trace_tb.sv ====
// Trace pipeline testbench
// Wishbone memory model fed from a data file, a stalling trace sink and a
// scoreboard that predicts every retired record
`timescale 1ns/1ps
`default_nettype none

module trace_tb;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0200;
  localparam int MAX_LINES = 64;
  localparam int FIELDS = 6;

  logic        clk_i;
  logic        rst_ni;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [31:0] wb_adr_o;
  logic [3:0]  wb_sel_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;
  logic        wb_err_i;
  logic        irq_ack_i;
  logic        dbg_ack_i;
  logic [2:0]  dbg_cause_i;
  logic        trace_ready_i;
  logic        rvfi_valid_o;
  logic [31:0] rvfi_pc_o;
  logic [31:0] rvfi_insn_o;
  logic        rvfi_intr_o;
  logic [1:0]  rvfi_trap_o;
  logic [5:0]  rvfi_cause_o;
  logic [2:0]  rvfi_dbg_o;
  logic [31:0] rvfi_mcause_o;

  // Six words per line in the order insn, err, wait states, irq, debug cause and sink stalls
  logic [31:0] td [0:FIELDS*MAX_LINES-1];
  int          num_lines = 0;
  int          retired_cnt = 0;
  logic        exp_prev_trap = 1'b0;
  logic [31:0] exp_mcause = '0;
  logic [31:0] rng_q = 32'd63;

  trace_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_sel_o      (wb_sel_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .irq_ack_i     (irq_ack_i),
    .dbg_ack_i     (dbg_ack_i),
    .dbg_cause_i   (dbg_cause_i),
    .trace_ready_i (trace_ready_i),
    .rvfi_valid_o  (rvfi_valid_o),
    .rvfi_pc_o     (rvfi_pc_o),
    .rvfi_insn_o   (rvfi_insn_o),
    .rvfi_intr_o   (rvfi_intr_o),
    .rvfi_trap_o   (rvfi_trap_o),
    .rvfi_cause_o  (rvfi_cause_o),
    .rvfi_dbg_o    (rvfi_dbg_o),
    .rvfi_mcause_o (rvfi_mcause_o)
  );

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] line_field(input int k, input int f);
    return td[FIELDS*k+f];
  endfunction

  // Trap cause of a line by the class priority or 0 for a normal word
  function automatic logic [5:0] expected_cause(input logic [31:0] insn, input logic err);
    if (err) return 6'd1;
    else if (insn[1:0] != 2'b11) return 6'd2;
    else if (insn == 32'h0000_0073) return 6'd11;
    else if (insn == 32'h0010_0073) return 6'd3;
    else return 6'd0;
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Predicts record k from its data line and the last retired record
  task automatic check_record(input int k);
    logic [31:0] insn;
    logic [5:0]  cause;
    logic        exc;
    logic        irq;
    if (k >= num_lines) begin
      $display("a record retired after the last data line at %0d ns", $time);
      abort_run();
    end else begin
      insn  = line_field(k, 0);
      cause = expected_cause(insn, line_field(k, 1) != 0);
      exc   = (cause != 6'd0);
      irq   = (line_field(k, 3) != 0);
      if (exc) begin
        exp_mcause = {26'b0, cause};
      end else if (irq) begin
        exp_mcause = 32'h8000_000B;
      end
      check_field("rvfi_pc_o", rvfi_pc_o, BOOT_ADDR + 32'(4 * k));
      check_field("rvfi_insn_o", rvfi_insn_o, insn);
      check_field("rvfi_intr_o", 32'(rvfi_intr_o), 32'(irq || exp_prev_trap));
      check_field("rvfi_trap_o", 32'(rvfi_trap_o), {30'b0, cause == 6'd3, exc});
      check_field("rvfi_cause_o", 32'(rvfi_cause_o), 32'(cause));
      check_field("rvfi_dbg_o", 32'(rvfi_dbg_o), 32'(line_field(k, 4)));
      check_field("rvfi_mcause_o", rvfi_mcause_o, exp_mcause);
      exp_prev_trap = exc;
    end
  endtask

  ////////////////////
  // Processes
  ////////////////////

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Answers each request after its line's wait states and puts the events on the ack
  initial begin : wishbone_memory
    int line;
    int waited;
    wb_dat_i    = '0;
    wb_ack_i    = 1'b0;
    wb_err_i    = 1'b0;
    irq_ack_i   = 1'b0;
    dbg_ack_i   = 1'b0;
    dbg_cause_i = '0;
    line        = 0;
    waited      = 0;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      wb_ack_i    = 1'b0;
      wb_err_i    = 1'b0;
      irq_ack_i   = 1'b0;
      dbg_ack_i   = 1'b0;
      dbg_cause_i = '0;
      // Past the last line the request is left hanging so the pipe drains
      if (wb_cyc_o && wb_stb_o && line < num_lines) begin
        check_field("wb_adr_o", wb_adr_o, BOOT_ADDR + 32'(4 * line));
        check_field("wb_we_o", 32'(wb_we_o), 32'd0);
        check_field("wb_sel_o", 32'(wb_sel_o), 32'hF);
        if (waited < int'(line_field(line, 2))) begin
          waited++;
        end else begin
          wb_dat_i  = line_field(line, 0);
          wb_err_i  = (line_field(line, 1) != 0);
          wb_ack_i  = !wb_err_i;
          irq_ack_i = (line_field(line, 3) != 0);
          if (line_field(line, 4) != 0) begin
            dbg_ack_i   = 1'b1;
            dbg_cause_i = 3'(line_field(line, 4));
          end
          line++;
          waited = 0;
        end
      end
    end
  end

  // Drops ready for the line's stall count plus an occasional random burst
  initial begin : trace_sink
    int seen;
    int stall_left;
    trace_ready_i = 1'b0;
    seen          = 0;
    stall_left    = 0;
    wait (rst_ni === 1'b1);
    stall_left = int'(line_field(0, 5));
    forever begin
      @(negedge clk_i);
      if (retired_cnt != seen) begin
        seen  = retired_cnt;
        rng_q = xorshift(rng_q);
        stall_left = (rng_q[7:6] == 2'b11) ? int'(rng_q[2:0]) : 0;
        if (seen < num_lines) begin
          stall_left += int'(line_field(seen, 5));
        end
      end
      if (stall_left > 0) begin
        trace_ready_i = 1'b0;
        stall_left--;
      end else begin
        trace_ready_i = 1'b1;
      end
    end
  end

  // Outputs and ready are stable at the rising edge where a record retires
  initial begin : scoreboard
    forever begin
      @(posedge clk_i);
      if (rst_ni && rvfi_valid_o && trace_ready_i) begin
        check_record(retired_cnt);
        retired_cnt++;
      end
    end
  end

  initial begin : watchdog
    wait (rst_ni === 1'b1);
    repeat (num_lines * 40) @(posedge clk_i);
    $display("timeout with %0d of %0d records retired", retired_cnt, num_lines);
    abort_run();
  end

  initial begin : main
    rst_ni = 1'b0;
    $readmemh("bench/trace_testdata.txt", td);
    while (num_lines < MAX_LINES && !$isunknown(td[FIELDS*num_lines])) begin
      num_lines++;
    end
    if (num_lines == 0) begin
      $display("no stimulus lines were loaded from the data file");
      abort_run();
    end else begin
      repeat (8) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      wait (retired_cnt == num_lines);
      // Quiet period to catch duplicated records
      repeat (20) @(posedge clk_i);
      if (retired_cnt == num_lines && !rvfi_valid_o) begin
        $display("TEST RESULT: PASS");
        $finish;
      end else begin
        $display("an extra record is waiting on the trace port after all %0d lines retired",
                 num_lines);
        abort_run();
      end
    end
  end

endmodule

`default_nettype wire

// ==== bench/trace_testdata.txt ====
// insn err wait irq dbg_cause stall, all hex, one instruction per line
// line k sits at BOOT_ADDR + 4*k
00000013 0 0 0 0 0
00a00093 0 1 0 0 0
00000073 0 0 0 0 1
00000013 0 2 0 0 0
00000013 0 0 0 0 0
00100073 0 3 0 0 2
00208133 0 0 0 0 0
00004501 0 1 0 0 0
000001b7 1 2 0 0 0
00c00193 0 0 1 0 3
00000013 0 1 1 0 0
40308233 0 0 0 3 0
00000013 0 3 0 2 1
00100073 0 0 1 1 0
00000013 0 2 0 0 4
00000073 0 0 1 0 0
00000013 0 1 0 0 2
00000013 0 0 0 0 0

// ==== verilog.f ====
rtl/trace_pkg.sv
rtl/trace_fetch.sv
rtl/trace_decode.sv
rtl/trace_retire.sv
rtl/trace_top.sv
bench/trace_retire_asserts.sv
bench/trace_tb.sv

// ==== Bender.yml ====
package:
  name: trace_pipeline

sources:
  - rtl/trace_pkg.sv
  - rtl/trace_fetch.sv
  - rtl/trace_decode.sv
  - rtl/trace_retire.sv
  - rtl/trace_top.sv
  - target: test
    files:
      - bench/trace_retire_asserts.sv
      - bench/trace_tb.sv
